// File: logic/aluUnit.sv
/*
 * 8-bit ALU and NZVC status register.
 * Result and flags register at the end of Execute; untouched flags hold their value.
 */
`timescale 1ns/1ps

module aluUnit (
    input  logic             Sysclk,
    input  logic             resetbar,
    input  logic             aluEnable,
    input  pep9Pkg::microOpT microOp,
    input  pep9Pkg::byteT    regValue,
    output pep9Pkg::byteT    result,
    output pep9Pkg::flagsT   flags
);
    import pep9Pkg::*;

    localparam int Msb = DataWidth - 1;

    byteT               addA, addB, nextResult;
    logic               addCin, addOverflow, updNZ;
    logic [DataWidth:0] sum;
    flagsT              nextFlags;

    // Shared adder for add, subtract and negate
    always_comb
    begin
        case (microOp.op)
            opSub:
            begin
                addA   = regValue;
                addB   = ~microOp.operand;
                addCin = 1'b1;
            end
            opNeg:
            begin
                addA   = '0;
                addB   = ~regValue;
                addCin = 1'b1;
            end
            default:
            begin
                addA   = regValue;
                addB   = microOp.operand;
                addCin = 1'b0;
            end
        endcase
    end

    assign sum         = {1'b0, addA} + {1'b0, addB} + (DataWidth + 1)'(addCin);
    assign addOverflow = (addA[Msb] == addB[Msb]) && (sum[Msb] != addA[Msb]);

    always_comb
    begin
        nextFlags = flags;
        updNZ     = 1'b1;
        case (microOp.op)
            opLoad: nextResult = microOp.operand;
            opAdd, opSub, opNeg:
            begin
                nextResult  = sum[Msb:0];
                nextFlags.v = addOverflow;
                nextFlags.c = sum[DataWidth]; // Carry out
            end
            opAnd:  nextResult = regValue & microOp.operand;
            opOr:   nextResult = regValue | microOp.operand;
            opNot:  nextResult = ~regValue;
            opAsl:
            begin
                nextResult  = {regValue[Msb-1:0], 1'b0};
                nextFlags.c = regValue[Msb];
                nextFlags.v = regValue[Msb] ^ regValue[Msb-1];
            end
            opAsr:
            begin
                nextResult  = {regValue[Msb], regValue[Msb:1]}; // Sign kept
                nextFlags.c = regValue[0];
            end
            opRol:
            begin
                nextResult  = {regValue[Msb-1:0], flags.c};
                nextFlags.c = regValue[Msb];
                updNZ       = 1'b0;
            end
            opRor:
            begin
                nextResult  = {flags.c, regValue[Msb:1]};
                nextFlags.c = regValue[0];
                updNZ       = 1'b0;
            end
            default:
            begin
                nextResult = regValue;
                updNZ      = 1'b0;
            end
        endcase
        if (updNZ)
        begin
            nextFlags.n = nextResult[Msb];
            nextFlags.z = (nextResult == '0);
        end
    end

    always_ff @(posedge Sysclk)
    begin
        if (aluEnable)
            result <= nextResult;
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            flags <= '0;
        else if (aluEnable)
            flags <= nextFlags;
    end

endmodule

// File: logic/cpuTop.sv
/*
 * Top level of the multi-cycle Pep/9 core.
 * Bytes arrive on a credit-based stream and each instruction leaves as one retire record.
 */
`timescale 1ns/1ps

module cpuTop #(
    parameter int InstrDepth    = 4, // Also the source's starting credits
    parameter int RetireCredits = 2
) (
    input  logic             Sysclk,
    input  logic             resetbar,
    input  logic             instrValid,
    input  pep9Pkg::byteT    instrByte,
    output logic             instrCredit,
    output logic             retireValid,
    output pep9Pkg::retireT  retireRec,
    input  logic             retireCredit
);
    import pep9Pkg::*;

    logic    pop, notEmpty, specLoad, operandLoad, isUnary;
    logic    aluEnable, retire, hasCredit, writeEnable;
    byteT    headByte, regValue, aluResult;
    flagsT   aluFlags;
    microOpT microOp;

    // Compare instructions retire without touching the register
    assign writeEnable = retire & microOp.writeBack;
    assign retireValid = retire;

    assign retireRec.regSel    = microOp.regSel;
    assign retireRec.writeBack = microOp.writeBack;
    assign retireRec.result    = aluResult;
    assign retireRec.flags     = aluFlags;

    stageSequencer seq (
        .Sysclk, .resetbar, .notEmpty, .isUnary, .hasCredit,
        .pop, .specLoad, .operandLoad, .aluEnable, .retire
    );

    creditCounter #(.RetireCredits(RetireCredits)) credits (
        .Sysclk, .resetbar, .creditReturn(retireCredit), .spend(retire), .hasCredit
    );

    instrQueue #(.InstrDepth(InstrDepth)) queue (
        .Sysclk, .resetbar, .pushValid(instrValid), .pushByte(instrByte),
        .pop, .notEmpty, .headByte, .creditOut(instrCredit)
    );

    instrDecoder decoder (
        .Sysclk, .resetbar, .headByte, .specLoad, .operandLoad, .isUnary, .microOp
    );

    aluUnit alu (
        .Sysclk, .resetbar, .aluEnable, .microOp, .regValue,
        .result(aluResult), .flags(aluFlags)
    );

    regFile regs (
        .Sysclk, .resetbar,
        .readSel(microOp.regSel), .readValue(regValue),
        .writeEnable, .writeSel(microOp.regSel), .writeValue(aluResult)
    );

endmodule

// File: logic/creditCounter.sv
/*
 * Retire credits held by the core.
 * Loaded at reset, spent on each retire, refilled by the sink's return pulses.
 */
`timescale 1ns/1ps

module creditCounter #(
    parameter int RetireCredits = 2
) (
    input  logic Sysclk,
    input  logic resetbar,
    input  logic creditReturn,
    input  logic spend,
    output logic hasCredit
);

    localparam int CountWidth = $clog2(RetireCredits + 1);

    logic [CountWidth-1:0] count;

    assign hasCredit = (count != '0);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            count <= CountWidth'(RetireCredits);
        else if (creditReturn && !spend)
            count <= count + 1'b1;
        else if (spend && !creditReturn)
            count <= count - 1'b1; // Both at once cancel
    end

endmodule

// File: logic/instrDecoder.sv
/*
 * Captures the specifier and the immediate low byte as they are fetched.
 * Maps the opcode to an ALU operation, a register select and a write-back bit.
 */
`timescale 1ns/1ps

module instrDecoder (
    input  logic             Sysclk,
    input  logic             resetbar,
    input  pep9Pkg::byteT    headByte,
    input  logic             specLoad,
    input  logic             operandLoad,
    output logic             isUnary,
    output pep9Pkg::microOpT microOp
);
    import pep9Pkg::*;

    byteT specReg;
    byteT operandReg;
    logic specUnary;

    function automatic logic unaryCode(input byteT spec);
        return spec < 8'h28;
    endfunction

    // Sequencer needs the answer in the same cycle the specifier is popped
    assign isUnary   = specLoad ? unaryCode(headByte) : unaryCode(specReg);
    assign specUnary = unaryCode(specReg);

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
            specReg <= '0;
        else if (specLoad)
            specReg <= headByte;
    end

    always_ff @(posedge Sysclk)
    begin
        if (operandLoad)
            operandReg <= headByte; // High operand byte is dropped
    end

    always_comb
    begin
        microOp.operand   = operandReg;
        microOp.writeBack = 1'b1;
        if (specUnary)
        begin
            microOp.regSel = regSelT'(specReg[0]);
            case (specReg[7:1])
                7'h0C:   microOp.op = opNot;
                7'h0D:   microOp.op = opNeg;
                7'h0E:   microOp.op = opAsl;
                7'h0F:   microOp.op = opAsr;
                7'h10:   microOp.op = opRol;
                7'h11:   microOp.op = opRor;
                default:
                begin
                    microOp.op        = opOr; // Unsupported unary, no write
                    microOp.writeBack = 1'b0;
                end
            endcase
        end
        else
        begin
            microOp.regSel = regSelT'(specReg[3]);
            case (specReg[7:4])
                4'h6:    microOp.op = opAdd;
                4'h7:    microOp.op = opSub;
                4'h8:    microOp.op = opAnd;
                4'h9:    microOp.op = opOr;
                4'hC:    microOp.op = opLoad;
                4'hA:
                begin
                    microOp.op        = opSub; // CPWr sets flags only
                    microOp.writeBack = 1'b0;
                end
                default:
                begin
                    microOp.op        = opLoad;
                    microOp.writeBack = 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/instrQueue.sv
/*
 * Circular FIFO for incoming instruction bytes.
 * Never overflows while the source keeps to its credits; one credit returns per pop.
 */
`timescale 1ns/1ps

module instrQueue #(
    parameter int InstrDepth = 4
) (
    input  logic          Sysclk,
    input  logic          resetbar,
    input  logic          pushValid,
    input  pep9Pkg::byteT pushByte,
    input  logic          pop,
    output logic          notEmpty,
    output pep9Pkg::byteT headByte,
    output logic          creditOut
);
    import pep9Pkg::*;

    localparam int AddrWidth = $clog2(InstrDepth);

    byteT                 mem [InstrDepth];
    logic [AddrWidth:0]   wrPtr, rdPtr; // Extra wrap bit

    assign notEmpty = (wrPtr != rdPtr);
    assign headByte = mem[rdPtr[AddrWidth-1:0]];

    always_ff @(posedge Sysclk)
    begin
        if (pushValid)
            mem[wrPtr[AddrWidth-1:0]] <= pushByte;
    end

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            creditOut <= 1'b0;
        end
        else
        begin
            if (pushValid)
                wrPtr <= wrPtr + 1'b1;
            if (pop && notEmpty)
                rdPtr <= rdPtr + 1'b1;
            creditOut <= pop && notEmpty; // Credit follows the pop by one cycle
        end
    end

endmodule

// File: logic/pep9Pkg.sv
/*
 * Shared types for the 8-bit Pep/9 core.
 * Modules import this package inside their bodies and use scoped names in port lists.
 */
package pep9Pkg;

    // Data path width
    parameter int DataWidth = 8;

    // One data or instruction byte
    typedef logic [DataWidth-1:0] byteT;

    // ALU operations, CPWr shares opSub with SUBr
    typedef enum logic [3:0]
    {
        opLoad = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAnd  = 4'd3,
        opOr   = 4'd4,
        opNot  = 4'd5,
        opNeg  = 4'd6,
        opAsl  = 4'd7,
        opAsr  = 4'd8,
        opRol  = 4'd9,
        opRor  = 4'd10
    } aluOpT;

    // Register bit of the specifier
    typedef enum logic
    {
        regA = 1'b0,
        regX = 1'b1
    } regSelT;

    // Status bits NZVC
    typedef struct packed
    {
        logic n;
        logic z;
        logic v;
        logic c;
    } flagsT;

    // Decoded instruction as seen by the ALU and write-back
    typedef struct packed
    {
        aluOpT  op;
        regSelT regSel;    // Source and destination register
        logic   writeBack; // Cleared for compare
        byteT   operand;   // Immediate low byte
    } microOpT;

    // One record per retired instruction
    typedef struct packed
    {
        regSelT regSel;
        logic   writeBack;
        byteT   result;
        flagsT  flags;
    } retireT;

endpackage

// File: logic/regFile.sv
/*
 * A and X accumulators.
 * Combinational read for the ALU, synchronous write from Store.
 */
`timescale 1ns/1ps

module regFile (
    input  logic            Sysclk,
    input  logic            resetbar,
    input  pep9Pkg::regSelT readSel,
    output pep9Pkg::byteT   readValue,
    input  logic            writeEnable,
    input  pep9Pkg::regSelT writeSel,
    input  pep9Pkg::byteT   writeValue
);
    import pep9Pkg::*;

    byteT regAValue;
    byteT regXValue;

    assign readValue = (readSel == regX) ? regXValue : regAValue;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            regAValue <= '0;
            regXValue <= '0;
        end
        else if (writeEnable)
        begin
            if (writeSel == regX)
                regXValue <= writeValue;
            else
                regAValue <= writeValue;
        end
    end

endmodule

// File: logic/stageSequencer.sv
/*
 * Steps each instruction through Fetch, Decode, Execute and Store.
 * Fetch pops one byte per cycle, Store holds until a retire credit is free.
 */
`timescale 1ns/1ps

module stageSequencer (
    input  logic Sysclk,
    input  logic resetbar,
    input  logic notEmpty,
    input  logic isUnary,
    input  logic hasCredit,
    output logic pop,
    output logic specLoad,
    output logic operandLoad,
    output logic aluEnable,
    output logic retire
);

    typedef enum logic [1:0]
    {
        stFetch   = 2'd0,
        stDecode  = 2'd1,
        stExecute = 2'd2,
        stStore   = 2'd3
    } stateT;

    stateT      state;
    logic [1:0] byteIdx; // 0 specifier, 1 operand high, 2 operand low
    logic       lastByte;

    assign pop         = (state == stFetch) && notEmpty;
    assign specLoad    = pop && (byteIdx == 2'd0);
    assign operandLoad = pop && (byteIdx == 2'd2);
    assign aluEnable   = (state == stExecute);
    assign retire      = (state == stStore) && hasCredit;

    // Unary ends after its specifier, the rest after the operand low byte
    assign lastByte = (specLoad && isUnary) || operandLoad;

    always_ff @(posedge Sysclk)
    begin
        if (!resetbar)
        begin
            state   <= stFetch;
            byteIdx <= 2'd0;
        end
        else
        begin
            case (state)
                stFetch:
                begin
                    if (pop)
                    begin
                        if (lastByte)
                        begin
                            byteIdx <= 2'd0;
                            state   <= stDecode;
                        end
                        else
                        begin
                            byteIdx <= byteIdx + 2'd1;
                        end
                    end
                end
                stDecode:  state <= stExecute;
                stExecute: state <= stStore; // Result registered here
                stStore:
                begin
                    if (hasCredit)
                    begin
                        state <= stFetch;
                    end
                end
                default:   state <= stFetch;
            endcase
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the core and its testbench with Verilator, run it and search the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module cpuTb -f verilog.f -o cpuTbSim \
    && ./obj_dir/cpuTbSim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
exit 0

// File: sim/cpuTb.sv
/*
 * Testbench for cpuTop with a credit-driven byte source, a retire sink and a reference model.
 * Expected retire records queue up as instructions are sent and a monitor checks them in order.
 */
`timescale 1ns/1ps

module cpuTb;
    import pep9Pkg::*;

    localparam int          InstrDepth    = 4;
    localparam int          RetireCredits = 2;
    localparam logic [31:0] Seed          = 32'h1da0292e;

    // AND, OR and the six unary ops
    localparam byteT LogicOps [8] = '{8'h80, 8'h90, 8'h18, 8'h1A, 8'h1C, 8'h1E, 8'h20, 8'h22};
    localparam byteT MixedOps [16] = '{8'h60, 8'h70, 8'h80, 8'h90, 8'hA0, 8'hC0, 8'h18, 8'h1A,
                                       8'h1C, 8'h1E, 8'h20, 8'h22, 8'h60, 8'h70, 8'h80, 8'hC0};

    logic   Sysclk = 1'b0;
    logic   resetbar;
    logic   instrValid;
    byteT   instrByte;
    logic   instrCredit;
    logic   retireValid;
    retireT retireRec;
    logic   retireCredit;

    byteT        txQ [$];      // Bytes queued for the source
    retireT      expQ [$];     // Expected retire records
    int          txSent, creditsSpent;                 // Source side
    int          creditsBack, srcCredits, expSeen, retiredCount, monErrors; // Monitor side
    int          creditsReturned;                      // Sink side
    int          mainErrors, errBase, testsPassed, testsFailed;
    bit          sinkHold, idleCheck, timedOut;
    string       curTest;
    byteT        modA, modX;   // Reference model state
    flagsT       modFlags;
    logic [31:0] dataRng, srcRng, sinkRng;

    always #2 Sysclk = ~Sysclk;

    cpuTop #(.InstrDepth(InstrDepth), .RetireCredits(RetireCredits)) uut (
        .Sysclk, .resetbar, .instrValid, .instrByte, .instrCredit,
        .retireValid, .retireRec, .retireCredit
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextData();
        dataRng = xorshift32(dataRng);
        return dataRng;
    endfunction

    // Register bit sits at bit 0 for unary and at bit 3 otherwise
    function automatic byteT makeSpec(input byteT base, input logic regBit, input logic [2:0] aaa);
        if (base < 8'h28)
            return base | {7'd0, regBit};
        return base | {4'd0, regBit, aaa};
    endfunction

    // Applies the instruction to the model, queues its bytes and its expected record
    task automatic sendInstr(input byteT spec, input byteT operand);
        logic       unary, sel, wb, nz;
        byteT       r, res;
        logic [8:0] s;
        flagsT      f;
        retireT     rec;
        unary = (spec < 8'h28);
        sel   = unary ? spec[0] : spec[3];
        r     = sel ? modX : modA;
        f     = modFlags;
        wb    = 1'b1;
        nz    = 1'b1;
        res   = r;
        s     = '0;
        if (unary)
        begin
            case (spec[7:1])
                7'h0C: res = ~r;
                7'h0D:
                begin
                    res = 8'h00 - r;
                    f.v = (r == 8'h80);
                    f.c = (r == 8'h00); // Carry out of 0 + ~r + 1
                end
                7'h0E:
                begin
                    res = {r[6:0], 1'b0};
                    f.c = r[7];
                    f.v = r[7] ^ res[7];
                end
                7'h0F:
                begin
                    res = {r[7], r[7:1]};
                    f.c = r[0];
                end
                7'h10:
                begin
                    res = {r[6:0], modFlags.c};
                    f.c = r[7];
                    nz  = 1'b0;
                end
                default:
                begin
                    res = {modFlags.c, r[7:1]};
                    f.c = r[0];
                    nz  = 1'b0;
                end
            endcase
        end
        else
        begin
            case (spec[7:4])
                4'h6:
                begin
                    s   = {1'b0, r} + {1'b0, operand};
                    res = s[7:0];
                    f.v = (r[7] == operand[7]) && (res[7] != r[7]);
                    f.c = s[8];
                end
                4'h7, 4'hA:
                begin
                    s   = {1'b0, r} + {1'b0, ~operand} + 9'd1;
                    res = s[7:0];
                    f.v = (r[7] != operand[7]) && (res[7] != r[7]);
                    f.c = s[8];
                    wb  = (spec[7:4] == 4'h7); // Compare leaves the register
                end
                4'h8: res = r & operand;
                4'h9: res = r | operand;
                default: res = operand;
            endcase
        end
        if (nz)
        begin
            f.n = res[7];
            f.z = (res == 8'h00);
        end
        if (wb && sel)
            modX = res;
        else if (wb)
            modA = res;
        modFlags      = f;
        rec.regSel    = regSelT'(sel);
        rec.writeBack = wb;
        rec.result    = res;
        rec.flags     = f;
        expQ.push_back(rec);
        txQ.push_back(spec);
        if (!unary)
        begin
            txQ.push_back(byteT'(nextData() >> 8)); // High byte the core ignores
            txQ.push_back(operand);
        end
    endtask

    task automatic beginTest(input string name);
        curTest = name;
        errBase = monErrors + mainErrors;
    endtask

    task automatic endTest();
        int errs;
        errs = monErrors + mainErrors - errBase;
        if (errs == 0 && !timedOut)
        begin
            testsPassed++;
            $display("[pass] %s", curTest);
        end
        else
        begin
            testsFailed++;
            $display("[fail] %s: %0d errors%s", curTest, errs, timedOut ? ", timed out" : "");
        end
    endtask

    task automatic waitDrain(input int limit);
        int cnt;
        cnt = 0;
        while ((txSent < txQ.size() || expSeen < expQ.size()) && cnt < limit)
        begin
            @(posedge Sysclk);
            cnt++;
        end
        if (txSent < txQ.size() || expSeen < expQ.size())
        begin
            $display("Timeout in %s: %0d of %0d records retired after %0d cycles",
                     curTest, expSeen, expQ.size(), cnt);
            timedOut = 1'b1;
        end
    endtask

    // Byte source spends one credit per byte with random gaps
    initial
    begin
        instrValid = 1'b0;
        instrByte  = '0;
        srcRng     = xorshift32(Seed);
        forever
        begin
            @(posedge Sysclk);
            #1;
            srcRng = xorshift32(srcRng);
            if (txSent < txQ.size() && InstrDepth + creditsBack - creditsSpent > 0
                && srcRng[1:0] != 2'd0)
            begin
                instrValid = 1'b1;
                instrByte  = txQ[txSent];
                txSent++;
                creditsSpent++;
            end
            else
            begin
                instrValid = 1'b0;
            end
        end
    end

    // Retire sink returns credits unless held off
    initial
    begin
        retireCredit = 1'b0;
        sinkRng      = xorshift32(xorshift32(Seed));
        forever
        begin
            @(posedge Sysclk);
            #1;
            sinkRng = xorshift32(sinkRng);
            if (!sinkHold && retiredCount > creditsReturned && sinkRng[0])
            begin
                retireCredit = 1'b1;
                creditsReturned++;
            end
            else
            begin
                retireCredit = 1'b0;
            end
        end
    end

    // Monitor samples on the falling edge where outputs have settled
    always @(negedge Sysclk)
    begin
        if (instrCredit === 1'b1)
            creditsBack++;
        srcCredits = InstrDepth + creditsBack - creditsSpent;
        assert (srcCredits >= 0 && srcCredits <= InstrDepth)
        else
        begin
            $display("Source credit count out of range in %s: %0d", curTest, srcCredits);
            monErrors++;
        end
        if (idleCheck)
        begin
            assert (retireValid === 1'b0 && instrCredit === 1'b0)
            else
            begin
                $display("Output active with no input in %s", curTest);
                monErrors++;
            end
        end
        if (retireValid === 1'b1)
        begin
            retiredCount++;
            assert (retiredCount - creditsReturned <= RetireCredits)
            else
            begin
                $display("More retires outstanding than credits in %s", curTest);
                monErrors++;
            end
            assert (expSeen < expQ.size())
            else
            begin
                $display("Retire with no instruction expected in %s", curTest);
                monErrors++;
            end
            if (expSeen < expQ.size())
            begin
                assert (retireRec === expQ[expSeen])
                else
                begin
                    $display("MISMATCH %s: expected %h, actual %h", curTest, expQ[expSeen],
                             retireRec);
                    monErrors++;
                end
                expSeen++;
            end
        end
    end

    task automatic idleAfterReset();
        beginTest("reset and load");
        idleCheck = 1'b1;
        repeat (20) @(posedge Sysclk);
        idleCheck = 1'b0;
        sendInstr(8'hC0, 8'h85); // Negative into A
        sendInstr(8'hC8, 8'h00); // Zero into X
        waitDrain(200);
        endTest();
    endtask

    task automatic addSubCompare();
        beginTest("add sub compare");
        sendInstr(8'hC0, 8'h7F);
        sendInstr(8'h60, 8'h01); // Signed overflow
        sendInstr(8'h60, 8'hFF); // Carry out
        sendInstr(8'hC8, 8'h80);
        sendInstr(8'h78, 8'h01); // 0x80 - 1 overflows
        sendInstr(8'h78, 8'h7F);
        sendInstr(8'hA0, 8'h80);
        sendInstr(8'h60, 8'h00); // A still holds the value before the compare
        sendInstr(8'hA8, 8'h01);
        sendInstr(8'h68, 8'h00);
        waitDrain(400);
        endTest();
    endtask

    task automatic logicAndShifts();
        int          i;
        logic [31:0] r;
        beginTest("logic and shifts");
        for (i = 0; i < 24; i++)
        begin
            r = nextData();
            if (i % 4 == 0)
                sendInstr({4'hC, r[3], 3'd0}, r[23:16]);
            sendInstr(makeSpec(LogicOps[r[2:0]], r[3], r[6:4]), r[15:8]);
        end
        waitDrain(1500);
        endTest();
    endtask

    task automatic retireBackpressure();
        int          i, cnt, held;
        logic [31:0] r;
        beginTest("retire back-pressure");
        sinkHold = 1'b1;
        for (i = 0; i < 6; i++)
        begin
            r = nextData();
            sendInstr(makeSpec(MixedOps[r[3:0]], r[4], r[7:5]), r[15:8]);
        end
        cnt = 0;
        while (retiredCount - creditsReturned < RetireCredits && cnt < 300)
        begin
            @(posedge Sysclk);
            cnt++;
        end
        if (retiredCount - creditsReturned < RetireCredits)
        begin
            $display("Timeout in %s: core never used up its retire credits", curTest);
            timedOut = 1'b1;
        end
        else
        begin
            held = retiredCount;
            repeat (16) @(posedge Sysclk);
            assert (retiredCount == held)
            else
            begin
                $display("Core retired while holding no credit in %s", curTest);
                mainErrors++;
            end
        end
        sinkHold = 1'b0;
        waitDrain(600);
        endTest();
    endtask

    task automatic instrCreditReturn();
        int          i, cnt;
        logic [31:0] r;
        beginTest("instruction credits");
        for (i = 0; i < 40; i++)
        begin
            r = nextData();
            sendInstr(makeSpec(MixedOps[r[3:0]], r[4], r[7:5]), r[15:8]);
        end
        waitDrain(3000);
        cnt = 0;
        while (srcCredits != InstrDepth && cnt < 50)
        begin
            @(posedge Sysclk);
            cnt++;
        end
        assert (srcCredits == InstrDepth)
        else
        begin
            $display("MISMATCH %s: expected %0d, actual %0d", curTest, InstrDepth, srcCredits);
            mainErrors++;
        end
        endTest();
    endtask

    initial
    begin
        resetbar = 1'b0;
        dataRng  = Seed;
        modA     = '0; // Model starts where reset leaves the core
        modX     = '0;
        modFlags = '0;
        repeat (5) @(posedge Sysclk);
        #1 resetbar = 1'b1;
        idleAfterReset();
        if (!timedOut)
            addSubCompare();
        if (!timedOut)
            logicAndShifts();
        if (!timedOut)
            retireBackpressure();
        if (!timedOut)
            instrCreditReturn();
        @(posedge Sysclk);
        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 testsPassed, testsFailed, monErrors + mainErrors);
        if (testsFailed == 0 && !timedOut && monErrors + mainErrors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: verilog.f
logic/pep9Pkg.sv
logic/creditCounter.sv
logic/instrQueue.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/regFile.sv
logic/stageSequencer.sv
logic/cpuTop.sv
sim/cpuTb.sv
